/* verilog/motorCfgPkg.sv */
package motorCfgPkg;

    // duty, step length and accumulator words
    localparam int dataW = 16;
    // commutation step code
    localparam int stepW = 4;

    // pwm period in clock cycles
    localparam int pwmPeriod = 64;
    // pulses shorter than this are carried into the next period
    localparam int minPulse = 8;
    // both gates stay off this long after a rising pwm edge
    localparam int deadTime = 2;
    // queue entries, also the initial credits of the sender
    localparam int queueDepth = 4;

    // derived counter widths
    localparam int ptrW = $clog2(queueDepth);
    localparam int periodW = $clog2(pwmPeriod + 1);
    localparam int deadW = $clog2(deadTime + 1);

endpackage

/* verilog/motorStepPkg.sv */
package motorStepPkg;

    // phase B waits for phase C's sum on this step
    localparam logic [motorCfgPkg::stepW-1:0] stepGateB = motorCfgPkg::stepW'(6);
    // phase C waits for phase B's sum on this step
    localparam logic [motorCfgPkg::stepW-1:0] stepGateC = motorCfgPkg::stepW'(11);

    // a new commutation cycle starts here, lost total restarts
    localparam logic [motorCfgPkg::stepW-1:0] stepResetLost [2] = '{
        motorCfgPkg::stepW'(1),
        motorCfgPkg::stepW'(7)
    };

    // codes up to this one drive the high gate, the rest the low gate
    localparam logic [motorCfgPkg::stepW-1:0] highSideLast = motorCfgPkg::stepW'(5);

    function automatic logic isHighSide(input logic [motorCfgPkg::stepW-1:0] code);
        return code <= highSideLast;
    endfunction

    function automatic logic restartsLost(input logic [motorCfgPkg::stepW-1:0] code);
        return (code == stepResetLost[0]) || (code == stepResetLost[1]);
    endfunction

endpackage

/* verilog/stepIf.sv */
`timescale 1ns/1ns

interface stepIf;
    import motorCfgPkg::*;

    // a step is playing
    logic active;
    // code and per-phase duty of the current step
    logic [stepW-1:0] sgStep;
    logic [dataW-1:0] dutyA;
    logic [dataW-1:0] dutyB;
    logic [dataW-1:0] dutyC;
    // step cycles 0 and 1, then len-2 and len-1
    logic first2;
    logic first1;
    logic last2;
    logic last1;

    // timebase side
    modport src(output active, sgStep, dutyA, dutyB, dutyC, first2, first1, last2, last1);
    // phase generator side
    modport sink(input active, sgStep, dutyA, dutyB, dutyC, first2, first1, last2, last1);

endinterface

/* verilog/stepCmdQueue.sv */
`timescale 1ns/1ns

module stepCmdQueue (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            cmdValid,
    input  logic [motorCfgPkg::stepW-1:0]   cmdStep,
    input  logic [motorCfgPkg::dataW-1:0]   cmdLen,
    input  logic [motorCfgPkg::dataW-1:0]   cmdDutyA,
    input  logic [motorCfgPkg::dataW-1:0]   cmdDutyB,
    input  logic [motorCfgPkg::dataW-1:0]   cmdDutyC,
    input  logic                            take,
    output logic                            headValid,
    output logic [motorCfgPkg::stepW-1:0]   headStep,
    output logic [motorCfgPkg::dataW-1:0]   headLen,
    output logic [motorCfgPkg::dataW-1:0]   headDutyA,
    output logic [motorCfgPkg::dataW-1:0]   headDutyB,
    output logic [motorCfgPkg::dataW-1:0]   headDutyC,
    output logic                            cmdCredit
);
    import motorCfgPkg::*;

    // entry storage, one array per field
    logic [stepW-1:0] stepMem [queueDepth];
    logic [dataW-1:0] lenMem [queueDepth];
    logic [dataW-1:0] dutyAMem [queueDepth];
    logic [dataW-1:0] dutyBMem [queueDepth];
    logic [dataW-1:0] dutyCMem [queueDepth];

    logic [ptrW-1:0] wrPtr;
    logic [ptrW-1:0] rdPtr;
    logic [ptrW:0] count;
    logic doWrite;
    logic doRead;

    // sender holds credits, so a write into a full queue is simply dropped
    assign doWrite = cmdValid & (count != (ptrW + 1)'(queueDepth));
    assign doRead = take & headValid;

    always_ff @(posedge clk) begin
        if (doWrite) begin
            stepMem[wrPtr] <= cmdStep;
            lenMem[wrPtr] <= cmdLen;
            dutyAMem[wrPtr] <= cmdDutyA;
            dutyBMem[wrPtr] <= cmdDutyB;
            dutyCMem[wrPtr] <= cmdDutyC;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
            cmdCredit <= 1'b0;
        end else begin
            if (doWrite) begin
                wrPtr <= (wrPtr == ptrW'(queueDepth - 1)) ? '0 : wrPtr + ptrW'(1);
            end
            if (doRead) begin
                rdPtr <= (rdPtr == ptrW'(queueDepth - 1)) ? '0 : rdPtr + ptrW'(1);
            end
            // occupancy, push and pop may coincide
            if (doWrite && !doRead) begin
                count <= count + (ptrW + 1)'(1);
            end else if (doRead && !doWrite) begin
                count <= count - (ptrW + 1)'(1);
            end
            // one credit back per popped entry
            cmdCredit <= doRead;
        end
    end

    // head entry straight from storage
    assign headValid = count != '0;
    assign headStep = stepMem[rdPtr];
    assign headLen = lenMem[rdPtr];
    assign headDutyA = dutyAMem[rdPtr];
    assign headDutyB = dutyBMem[rdPtr];
    assign headDutyC = dutyCMem[rdPtr];

endmodule

/* verilog/stepTimebase.sv */
`timescale 1ns/1ns

module stepTimebase (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            headValid,
    input  logic [motorCfgPkg::stepW-1:0]   headStep,
    input  logic [motorCfgPkg::dataW-1:0]   headLen,
    input  logic [motorCfgPkg::dataW-1:0]   headDutyA,
    input  logic [motorCfgPkg::dataW-1:0]   headDutyB,
    input  logic [motorCfgPkg::dataW-1:0]   headDutyC,
    output logic                            take,
    stepIf.src                              step
);
    import motorCfgPkg::*;

    logic playing;
    logic [dataW-1:0] cnt;
    logic [stepW-1:0] curStep;
    logic [dataW-1:0] curLen;
    logic [dataW-1:0] curDutyA;
    logic [dataW-1:0] curDutyB;
    logic [dataW-1:0] curDutyC;
    logic atLast1;

    // step length is at least 8, so the four strobes never overlap
    assign atLast1 = playing & (cnt == curLen - dataW'(1));

    // take when idle, or on the last cycle so steps run back to back
    assign take = headValid & (~playing | atLast1);

    always_ff @(posedge clk) begin
        if (rst) begin
            playing <= 1'b0;
            cnt <= '0;
            curStep <= '0;
        end else if (take) begin
            playing <= 1'b1;
            cnt <= '0;
            curStep <= headStep;
        end else if (atLast1) begin
            // nothing waiting, go idle
            playing <= 1'b0;
        end else if (playing) begin
            cnt <= cnt + dataW'(1);
        end
    end

    // step payload
    always_ff @(posedge clk) begin
        if (take) begin
            curLen <= headLen;
            curDutyA <= headDutyA;
            curDutyB <= headDutyB;
            curDutyC <= headDutyC;
        end
    end

    assign step.active = playing;
    assign step.sgStep = curStep;
    assign step.dutyA = curDutyA;
    assign step.dutyB = curDutyB;
    assign step.dutyC = curDutyC;
    // boundary strobes decoded from the step counter
    assign step.first2 = playing & (cnt == '0);
    assign step.first1 = playing & (cnt == dataW'(1));
    assign step.last2 = playing & (cnt == curLen - dataW'(2));
    assign step.last1 = atLast1;

endmodule

/* verilog/pwmPhaseGen.sv */
`timescale 1ns/1ns

module pwmPhaseGen #(
    // step on which this phase only fires if posSumExt is at least its own sum
    parameter logic [motorCfgPkg::stepW-1:0] gateStep = motorStepPkg::stepGateB
) (
    input  logic                            clk,
    input  logic                            rst,
    stepIf.sink                             step,
    input  logic [motorCfgPkg::dataW-1:0]   duty,
    input  logic [motorCfgPkg::dataW-1:0]   posSumExt,
    output logic [motorCfgPkg::dataW-1:0]   posSum,
    output logic                            pwm
);
    import motorCfgPkg::*;
    import motorStepPkg::*;

    logic [periodW-1:0] periodCnt;
    logic periodStart;
    logic [dataW-1:0] pulseCnt;
    logic [dataW-1:0] remain;
    logic [dataW-1:0] wantAcc;
    logic [dataW-1:0] realAcc;
    logic [dataW-1:0] wantHold;
    logic [dataW-1:0] realHold;
    logic [dataW-1:0] lost;
    logic [dataW-1:0] lostDiff;
    logic [dataW-1:0] lostNext;
    logic [dataW-1:0] lostJoin;
    logic gated;
    logic load;

    // first period opens at first1, later ones every pwmPeriod cycles
    assign periodStart = step.first1 | (step.active & (periodCnt == periodW'(1)));

    // held at full period across the step boundary
    always_ff @(posedge clk) begin
        if (rst) begin
            periodCnt <= periodW'(pwmPeriod);
        end else if (periodStart || step.last1) begin
            periodCnt <= periodW'(pwmPeriod);
        end else if (step.active) begin
            periodCnt <= periodCnt - periodW'(1);
        end
    end

    // only undelivered duty counts, over-delivery is not lost
    assign lostDiff = (wantHold > realHold) ? wantHold - realHold : '0;
    assign lostNext = (restartsLost(step.sgStep) ? '0 : lost) + lostDiff;
    // lost total rides on the first period of a step
    assign lostJoin = step.first1 ? lostNext : '0;
    assign posSum = remain + duty + lostJoin;

    // steps 6 and 11 wait for the partner phase
    assign gated = step.sgStep == gateStep;
    assign load = (posSum >= dataW'(minPulse)) && (!gated || (posSumExt >= posSum));

    // pulse counter, pwm comes out of a flop one cycle after the load
    always_ff @(posedge clk) begin
        if (rst) begin
            pulseCnt <= '0;
            pwm <= 1'b0;
        end else if (periodStart && load) begin
            pulseCnt <= posSum;
            pwm <= 1'b1;
        end else begin
            pwm <= pulseCnt > dataW'(1);
            if (pulseCnt != '0) begin
                pulseCnt <= pulseCnt - dataW'(1);
            end
        end
    end

    // short or skipped sums carry over, but never past the step end
    always_ff @(posedge clk) begin
        if (rst) begin
            remain <= '0;
        end else if (step.last2) begin
            remain <= '0;
        end else if (periodStart) begin
            remain <= load ? '0 : posSum;
        end
    end

    // want vs real per step, frozen at last2
    always_ff @(posedge clk) begin
        if (rst) begin
            wantAcc <= '0;
            realAcc <= '0;
            wantHold <= '0;
            realHold <= '0;
        end else if (step.last2) begin
            wantHold <= wantAcc;
            realHold <= realAcc;
            // a period opening right here belongs to the next step
            wantAcc <= periodStart ? duty : '0;
            realAcc <= dataW'(pwm);
        end else begin
            if (periodStart) begin
                wantAcc <= wantAcc + duty;
            end
            if (pwm) begin
                realAcc <= realAcc + dataW'(1);
            end
        end
    end

    // lost total, restarted on each new commutation cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            lost <= '0;
        end else if (step.first1) begin
            lost <= lostNext;
        end
    end

endmodule

/* verilog/gateDriveOut.sv */
`timescale 1ns/1ns

module gateDriveOut (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            pwm,
    input  logic [motorCfgPkg::stepW-1:0]   sgStep,
    output logic                            gateHi,
    output logic                            gateLo
);
    import motorCfgPkg::*;
    import motorStepPkg::*;

    logic pwmQ;
    logic sideHi;
    logic sideQ;
    logic restart;
    logic [deadW-1:0] deadCnt;
    logic [deadW-1:0] deadNext;
    logic open;

    assign sideHi = isHighSide(sgStep);
    // dead time restarts on a rising pwm edge or a side swap
    assign restart = (pwm & ~pwmQ) | (sideHi != sideQ);
    assign deadNext = restart ? deadW'(deadTime)
                    : (deadCnt != '0) ? deadCnt - deadW'(1) : '0;
    // rising edge reaches the gate deadTime+1 cycles late, falling edge 1 cycle
    assign open = pwm & (deadNext == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            pwmQ <= 1'b0;
            sideQ <= 1'b1;
            deadCnt <= '0;
            gateHi <= 1'b0;
            gateLo <= 1'b0;
        end else begin
            pwmQ <= pwm;
            sideQ <= sideHi;
            deadCnt <= deadNext;
            // the unselected gate stays off
            gateHi <= open & sideHi;
            gateLo <= open & ~sideHi;
        end
    end

endmodule

/* verilog/motorPwmTop.sv */
`timescale 1ns/1ns

module motorPwmTop (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            cmdValid,
    input  logic [motorCfgPkg::stepW-1:0]   cmdStep,
    input  logic [motorCfgPkg::dataW-1:0]   cmdLen,
    input  logic [motorCfgPkg::dataW-1:0]   cmdDutyA,
    input  logic [motorCfgPkg::dataW-1:0]   cmdDutyB,
    input  logic [motorCfgPkg::dataW-1:0]   cmdDutyC,
    output logic                            cmdCredit,
    output logic [2:0]                      gateHi,
    output logic [2:0]                      gateLo
);
    import motorCfgPkg::*;
    import motorStepPkg::*;

    logic headValid;
    logic [stepW-1:0] headStep;
    logic [dataW-1:0] headLen;
    logic [dataW-1:0] headDutyA;
    logic [dataW-1:0] headDutyB;
    logic [dataW-1:0] headDutyC;
    logic take;
    logic [dataW-1:0] sumA;
    logic [dataW-1:0] sumB;
    logic [dataW-1:0] sumC;
    logic [2:0] pwm;

    stepIf stepBus ();

    stepCmdQueue uCmdQueue (
        .clk(clk), .rst(rst),
        .cmdValid(cmdValid), .cmdStep(cmdStep), .cmdLen(cmdLen),
        .cmdDutyA(cmdDutyA), .cmdDutyB(cmdDutyB), .cmdDutyC(cmdDutyC),
        .take(take), .headValid(headValid), .headStep(headStep), .headLen(headLen),
        .headDutyA(headDutyA), .headDutyB(headDutyB), .headDutyC(headDutyC),
        .cmdCredit(cmdCredit)
    );

    stepTimebase uTimebase (
        .clk(clk), .rst(rst),
        .headValid(headValid), .headStep(headStep), .headLen(headLen),
        .headDutyA(headDutyA), .headDutyB(headDutyB), .headDutyC(headDutyC),
        .take(take), .step(stepBus.src)
    );

    // phase A is never gated, so it compares against its own sum
    pwmPhaseGen uPhaseA (
        .clk(clk), .rst(rst), .step(stepBus.sink), .duty(stepBus.dutyA),
        .posSumExt(sumA), .posSum(sumA), .pwm(pwm[0])
    );

    // B and C are cross-wired on their gated steps
    pwmPhaseGen #(.gateStep(stepGateB)) uPhaseB (
        .clk(clk), .rst(rst), .step(stepBus.sink), .duty(stepBus.dutyB),
        .posSumExt(sumC), .posSum(sumB), .pwm(pwm[1])
    );

    pwmPhaseGen #(.gateStep(stepGateC)) uPhaseC (
        .clk(clk), .rst(rst), .step(stepBus.sink), .duty(stepBus.dutyC),
        .posSumExt(sumB), .posSum(sumC), .pwm(pwm[2])
    );

    // one gate stage per phase, all steered by the current step code
    for (genvar i = 0; i < 3; i++) begin : gGate
        gateDriveOut uGate (
            .clk(clk), .rst(rst), .pwm(pwm[i]), .sgStep(stepBus.sgStep),
            .gateHi(gateHi[i]), .gateLo(gateLo[i])
        );
    end

endmodule

/* verif/clkGen.sv */
`timescale 1ns/1ns

module clkGen (
    output logic clk,
    output logic rst
);
    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset held for 4 rising edges, released just after the last one
    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

/* verif/motorPwmTb.sv */
`timescale 1ns/1ns

module motorPwmTb;
    import motorCfgPkg::*;

    localparam int numSteps = 16;
    localparam int cols = 6;
    // queue is drained before this command so the idle gap is seen
    localparam int idleAt = 12;

    logic clk;
    logic rst;
    logic cmdValid;
    logic [stepW-1:0] cmdStep;
    logic [dataW-1:0] cmdLen;
    logic [dataW-1:0] cmdDutyA;
    logic [dataW-1:0] cmdDutyB;
    logic [dataW-1:0] cmdDutyC;
    logic cmdCredit;
    logic [2:0] gateHi;
    logic [2:0] gateLo;

    // code, length, duty A, B, C, expected side per row
    logic [15:0] stim [numSteps*cols];
    logic [31:0] lfsrState;
    int errors;
    int credits;
    int creditPulses;
    int sent;
    int sendIdx;
    int limit;
    logic limitReady;
    logic started;

    // reference model state
    int qIdx [4];
    int qWr;
    int qRd;
    int qCnt;
    logic mPlaying;
    logic [15:0] mCnt;
    logic [15:0] mLen;
    logic [3:0] mStep;
    logic mSide;
    logic [15:0] mDuty [3];
    logic mCredit;
    logic [15:0] mPer;
    logic [15:0] pulse [3];
    logic pwmM [3];
    logic [15:0] remain [3];
    logic [15:0] wantAcc [3];
    logic [15:0] realAcc [3];
    logic [15:0] wantHold [3];
    logic [15:0] realHold [3];
    logic [15:0] lost [3];
    logic pwmQ [3];
    logic sideQ;
    int dead [3];
    logic [2:0] expHi;
    logic [2:0] expLo;

    clkGen uClk (.clk(clk), .rst(rst));

    motorPwmTop u_motorPwmTop (
        .clk(clk), .rst(rst), .cmdValid(cmdValid), .cmdStep(cmdStep), .cmdLen(cmdLen),
        .cmdDutyA(cmdDutyA), .cmdDutyB(cmdDutyB), .cmdDutyC(cmdDutyC),
        .cmdCredit(cmdCredit), .gateHi(gateHi), .gateLo(gateLo)
    );

    // fibonacci lfsr with taps 32 22 2 1 and one call per bit
    function automatic logic lfsrBit();
        logic fb;
        fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
        lfsrState = {lfsrState[30:0], fb};
        return fb;
    endfunction

    function automatic int lfsrBits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsrBit());
        end
        return v;
    endfunction

    task automatic checkValue(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
        if (got !== exp) begin
            $display("[ERROR] t=%0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic waitCycle();
        @(posedge clk);
        #1;
    endtask

    // advances the expected behavior by one clock in blocking order
    task automatic stepModel();
        logic atLast1;
        logic f1;
        logic l2;
        logic take;
        logic doWrite;
        logic ps;
        logic restart;
        logic open;
        logic [15:0] lostDiff;
        logic [15:0] lostNext;
        logic [15:0] sum [3];
        logic ld [3];
        logic pwmOld [3];
        int dn;
        int h;
        if (rst) begin
            qWr = 0;
            qRd = 0;
            qCnt = 0;
            mPlaying = 1'b0;
            mCnt = 16'd0;
            mStep = 4'd0;
            mSide = 1'b1;
            mCredit = 1'b0;
            mPer = 16'(pwmPeriod);
            sideQ = 1'b1;
            expHi = 3'b000;
            expLo = 3'b000;
            for (int p = 0; p < 3; p++) begin
                pulse[p] = 16'd0;
                pwmM[p] = 1'b0;
                remain[p] = 16'd0;
                wantAcc[p] = 16'd0;
                realAcc[p] = 16'd0;
                wantHold[p] = 16'd0;
                realHold[p] = 16'd0;
                lost[p] = 16'd0;
                pwmQ[p] = 1'b0;
                dead[p] = 0;
            end
            return;
        end
        // step boundaries
        atLast1 = mPlaying && (mCnt == mLen - 16'd1);
        f1 = mPlaying && (mCnt == 16'd1);
        l2 = mPlaying && (mCnt == mLen - 16'd2);
        take = (qCnt != 0) && (!mPlaying || atLast1);
        doWrite = cmdValid && (qCnt != queueDepth);
        ps = f1 || (mPlaying && (mPer == 16'd1));
        // sums come first since gating compares the partner phase
        for (int p = 0; p < 3; p++) begin
            lostDiff = (wantHold[p] > realHold[p]) ? wantHold[p] - realHold[p] : 16'd0;
            lostNext = ((mStep == 4'd1 || mStep == 4'd7) ? 16'd0 : lost[p]) + lostDiff;
            sum[p] = remain[p] + mDuty[p] + (f1 ? lostNext : 16'd0);
            if (f1) begin
                lost[p] = lostNext;
            end
        end
        for (int p = 0; p < 3; p++) begin
            ld[p] = sum[p] >= 16'(minPulse);
        end
        if (mStep == 4'd6 && sum[2] < sum[1]) begin
            ld[1] = 1'b0;
        end
        if (mStep == 4'd11 && sum[1] < sum[2]) begin
            ld[2] = 1'b0;
        end
        // gate stage sees the pwm of the previous clock
        for (int p = 0; p < 3; p++) begin
            pwmOld[p] = pwmM[p];
            restart = (pwmM[p] && !pwmQ[p]) || (mSide != sideQ);
            dn = restart ? deadTime : ((dead[p] > 0) ? dead[p] - 1 : 0);
            open = pwmM[p] && (dn == 0);
            expHi[p] = open && mSide;
            expLo[p] = open && !mSide;
            pwmQ[p] = pwmM[p];
            dead[p] = dn;
        end
        sideQ = mSide;
        for (int p = 0; p < 3; p++) begin
            if (ps && ld[p]) begin
                pulse[p] = sum[p];
                pwmM[p] = 1'b1;
            end else begin
                pwmM[p] = pulse[p] > 16'd1;
                if (pulse[p] != 16'd0) begin
                    pulse[p] = pulse[p] - 16'd1;
                end
            end
            if (l2) begin
                remain[p] = 16'd0;
                wantHold[p] = wantAcc[p];
                realHold[p] = realAcc[p];
                wantAcc[p] = ps ? mDuty[p] : 16'd0;
                realAcc[p] = {15'd0, pwmOld[p]};
            end else begin
                if (ps) begin
                    remain[p] = ld[p] ? 16'd0 : sum[p];
                    wantAcc[p] = wantAcc[p] + mDuty[p];
                end
                if (pwmOld[p]) begin
                    realAcc[p] = realAcc[p] + 16'd1;
                end
            end
        end
        if (ps || atLast1) begin
            mPer = 16'(pwmPeriod);
        end else if (mPlaying) begin
            mPer = mPer - 16'd1;
        end
        // timebase takes the head before the queue moves
        h = qIdx[qRd];
        if (take) begin
            mPlaying = 1'b1;
            mCnt = 16'd0;
            mStep = stim[h*cols][3:0];
            mLen = stim[h*cols+1];
            mSide = stim[h*cols+5][0];
            for (int p = 0; p < 3; p++) begin
                mDuty[p] = stim[h*cols+2+p];
            end
        end else if (atLast1) begin
            mPlaying = 1'b0;
        end else if (mPlaying) begin
            mCnt = mCnt + 16'd1;
        end
        if (doWrite) begin
            qIdx[qWr] = sendIdx;
            qWr = (qWr + 1) % 4;
        end
        if (take) begin
            qRd = (qRd + 1) % 4;
        end
        qCnt = qCnt + (doWrite ? 1 : 0) - (take ? 1 : 0);
        mCredit = take;
    endtask

    always @(posedge clk) begin
        stepModel();
        started <= 1'b1;
        if (cmdCredit === 1'b1) begin
            credits++;
            creditPulses++;
            // more credits back than were ever handed out
            if (credits > queueDepth) begin
                $display("credit returned with no command outstanding at t=%0t", $time);
                errors++;
            end
        end
    end

    // compare in mid cycle where the outputs have settled
    always @(negedge clk) begin
        if (started) begin
            checkValue("gateHi", {13'd0, gateHi}, {13'd0, expHi});
            checkValue("gateLo", {13'd0, gateLo}, {13'd0, expLo});
            checkValue("cmdCredit", {15'd0, cmdCredit}, {15'd0, mCredit});
            checkValue("gateHi&gateLo", {13'd0, gateHi & gateLo}, 16'd0);
            checkValue("gate on wrong side", {13'd0, sideQ ? gateLo : gateHi}, 16'd0);
        end
    end

    // watchdog bound is twice the total step length plus slack
    initial begin
        wait (limitReady === 1'b1);
        repeat (limit) @(posedge clk);
        $display("watchdog expired after %0d cycles with %0d errors, run did not finish",
                 limit, errors);
        $display("Test failed");
        $finish;
    end

    initial begin
        int total;
        int gap;
        cmdValid = 1'b0;
        cmdStep = '0;
        cmdLen = '0;
        cmdDutyA = '0;
        cmdDutyB = '0;
        cmdDutyC = '0;
        errors = 0;
        credits = queueDepth;
        creditPulses = 0;
        sent = 0;
        sendIdx = 0;
        started = 1'b0;
        limitReady = 1'b0;
        lfsrState = 32'h1b6afbcf;
        for (int p = 0; p < 3; p++) begin
            mDuty[p] = 16'd0;
        end
        $readmemh("verif/stepInput.dat", stim);
        total = 0;
        for (int k = 0; k < numSteps; k++) begin
            total += int'(stim[k*cols+1]);
        end
        limit = 2 * (total + 100);
        limitReady = 1'b1;
        wait (rst === 1'b0);
        waitCycle();
        for (int k = 0; k < numSteps; k++) begin
            gap = lfsrBits(3);
            repeat (gap) waitCycle();
            if (k == idleAt) begin
                while (qCnt != 0 || mPlaying) waitCycle();
                repeat (20) waitCycle();
            end
            while (credits == 0) waitCycle();
            sendIdx = k;
            cmdValid = 1'b1;
            cmdStep = stim[k*cols][stepW-1:0];
            cmdLen = stim[k*cols+1];
            cmdDutyA = stim[k*cols+2];
            cmdDutyB = stim[k*cols+3];
            cmdDutyC = stim[k*cols+4];
            credits--;
            sent++;
            waitCycle();
            cmdValid = 1'b0;
        end
        // let the last step play out and the gates fall
        while (qCnt != 0 || mPlaying) waitCycle();
        repeat (10) waitCycle();
        checkValue("credits", 16'(credits), 16'(queueDepth));
        checkValue("creditPulses", 16'(creditPulses), 16'(sent));
        $display("summary: %0d errors, %0d commands sent, %0d credits returned",
                 errors, sent, creditPulses);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* filelist.f */
verilog/motorCfgPkg.sv
verilog/motorStepPkg.sv
verilog/stepIf.sv
verilog/stepCmdQueue.sv
verilog/stepTimebase.sv
verilog/pwmPhaseGen.sv
verilog/gateDriveOut.sv
verilog/motorPwmTop.sv
verif/clkGen.sv
verif/motorPwmTb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       := motorPwmTb
FILELIST  := filelist.f
OBJDIR    := obj_dir
SIMBIN    := $(OBJDIR)/V$(TOP)
SIMLOG    := sim.log
DATAFILE  := verif/stepInput.dat

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run check clean

all: $(SIMBIN)

# rebuilt only when a source or the file list changes
$(SIMBIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(SIMBIN) $(DATAFILE)
	./$(SIMBIN) > $(SIMLOG); cat $(SIMLOG)

check: run
	@grep -q "^Test passed$$" $(SIMLOG)

clean:
	rm -rf $(OBJDIR) $(SIMLOG)

/* verif/stepInput.dat */
// one step per line, hex: code length dutyA dutyB dutyC side
// side is 1 where the high gate is expected, 0 for the low gate
0001 0080 0020 0010 0005 0001
0002 0060 0030 0006 0018 0001
0003 0050 0004 0028 0010 0001
0004 0070 001c 000c 0003 0001
0005 0048 0040 0008 0022 0001
0006 0080 0010 0030 000c 0000
0007 0064 0014 0002 0026 0000
0008 0058 000a 001e 0012 0000
0009 0090 0006 0011 002c 0000
000a 0040 003a 000f 0007 0000
000b 0080 000c 0008 0030 0000
0000 0008 0009 0007 000a 0001
0006 0060 0020 0008 0028 0000
0001 0050 0005 0005 0005 0001
000b 0070 0018 0034 000c 0000
000f 0044 002e 001b 0009 0000
